//--- common/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// byte address into the 32-bit space
`define DC_ADDR_W 32

// one CPU word, eight byte lanes
`define DC_WORD_W 64

// two ways of 16 sets each
`define DC_SETS 16
`define DC_INDEX_W 4

// 32-byte line, four words
`define DC_LINE_WORDS 4
`define DC_OFFSET_W 5

// address bits above index and offset
`define DC_TAG_W 23

`endif

//--- common/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

  // one load or store from the pipeline
  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic isWrite;
    logic [`DC_WORD_W-1:0] wrData;
    logic [`DC_WORD_W/8-1:0] byteMask;
  } cpuReq_t;

  // load data, zero for a store
  typedef struct packed {
    logic [`DC_WORD_W-1:0] data;
  } cpuResp_t;

  // line-aligned refill address
  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
  } memRdReq_t;

  // one write-back beat
  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_WORD_W-1:0] data;
  } memWrBeat_t;

  typedef enum logic [2:0] {
    Idle      = 3'd0,
    Compare   = 3'd1,
    WriteBack = 3'd2,
    RefillReq = 3'd3,
    Refill    = 3'd4,
    Install   = 3'd5
  } ctrlState_t;

  // data array write kind
  typedef enum logic [1:0] {
    None  = 2'd0,
    Store = 2'd1,
    Fill  = 2'd2
  } wayOp_t;

endpackage

//--- dcache/dcacheCtrl.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcacheCtrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reqValid_i,
  input  dcache_pkg::cpuReq_t   req_i,
  input  logic                  hit_i,
  input  logic                  hitWay_i,
  input  logic                  victimWay_i,
  input  logic                  victimDirty_i,
  input  logic                  memRdReady_i,
  input  logic                  memRdDataValid_i,
  input  logic                  memRdLast_i,
  input  logic                  memWrReady_i,
  output logic                  reqReady_o,
  output dcache_pkg::cpuReq_t   latchedReq_o,
  output logic                  respValid_o,
  output dcache_pkg::wayOp_t    dataOp_o,
  output logic                  opWay_o,
  output logic                  tagFill_o,
  output logic                  tagTouch_o,
  output logic                  storeHit_o,
  output logic                  fillBeat_o,
  output logic [$clog2(`DC_LINE_WORDS)-1:0] wbIndex_o,
  output logic                  memRdValid_o,
  output logic                  memWrValid_o,
  output logic                  memWrLast_o
);
  import dcache_pkg::*;

  ctrlState_t state;
  ctrlState_t stateNext;
  logic [$clog2(`DC_LINE_WORDS)-1:0] wbCnt;
  logic hitNow;
  logic accept;

  // a lookup result only counts in Compare
  assign hitNow = (state == Compare) && hit_i;
  assign reqReady_o = (state == Idle) || hitNow;
  assign accept = reqValid_i && reqReady_o;

  assign respValid_o = hitNow;
  assign tagTouch_o = hitNow;
  assign storeHit_o = hitNow && latchedReq_o.isWrite;
  assign tagFill_o = (state == Install);

  // hit way on lookup, victim way for write-back and install
  assign opWay_o = (state == Compare) ? hitWay_i : victimWay_i;

  always_comb begin
    if (state == Install) begin
      dataOp_o = Fill;
    end else if (storeHit_o) begin
      dataOp_o = Store;
    end else begin
      dataOp_o = None;
    end
  end

  assign memRdValid_o = (state == RefillReq);
  assign memWrValid_o = (state == WriteBack);
  assign memWrLast_o = memWrValid_o && (wbCnt == '1);
  assign wbIndex_o = wbCnt;
  assign fillBeat_o = (state == Refill) && memRdDataValid_i;

  always_ff @(posedge clk) begin
    if (accept) begin
      latchedReq_o <= req_i;
    end
  end

  // counts accepted write-back beats, wraps after the last one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wbCnt <= '0;
    end else if (memWrValid_o && memWrReady_i) begin
      wbCnt <= wbCnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      Idle: begin
        if (accept) begin
          stateNext = Compare;
        end
      end
      Compare: begin
        if (hit_i) begin
          // back-to-back hits stay here
          stateNext = accept ? Compare : Idle;
        end else if (victimDirty_i) begin
          stateNext = WriteBack;
        end else begin
          stateNext = RefillReq;
        end
      end
      WriteBack: begin
        if (memWrReady_i && memWrLast_o) begin
          stateNext = RefillReq;
        end
      end
      RefillReq: begin
        if (memRdReady_i) begin
          stateNext = Refill;
        end
      end
      Refill: begin
        if (memRdDataValid_i && memRdLast_i) begin
          stateNext = Install;
        end
      end
      Install: begin
        // replay the access, it hits now
        stateNext = Compare;
      end
      default: begin
        stateNext = Idle;
      end
    endcase
  end

endmodule

//--- dcache/tagStore.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module tagStore (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`DC_ADDR_W-1:0] addr_i,
  input  logic                  fill_i,
  input  logic                  touch_i,
  input  logic                  fillWay_i,
  input  logic                  storeHit_i,
  output logic                  hit_o,
  output logic                  hitWay_o,
  output logic                  victimWay_o,
  output logic                  victimDirty_o,
  output logic [`DC_ADDR_W-1:0] victimAddr_o
);

  logic [`DC_TAG_W-1:0] tags [2][`DC_SETS];
  logic [1:0][`DC_SETS-1:0] valid;
  logic [1:0][`DC_SETS-1:0] dirty;
  // least recently used way of each set
  logic [`DC_SETS-1:0] lru;

  logic [`DC_INDEX_W-1:0] index;
  logic [`DC_TAG_W-1:0] tag;
  logic [1:0] wayHit;

  assign index = addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
  assign tag = addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = valid[w][index] && (tags[w][index] == tag);
    end
  end

  assign hit_o = |wayHit;
  assign hitWay_o = wayHit[1];

  // empty way first, way 0 before way 1, else LRU
  assign victimWay_o = !valid[0][index] ? 1'b0 :
                       !valid[1][index] ? 1'b1 : lru[index];
  assign victimDirty_o = valid[victimWay_o][index] && dirty[victimWay_o][index];
  assign victimAddr_o = {tags[victimWay_o][index], index, {`DC_OFFSET_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (fill_i) begin
      tags[fillWay_i][index] <= tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
      dirty <= '0;
      lru <= '0;
    end else if (fill_i) begin
      valid[fillWay_i][index] <= 1'b1;
      dirty[fillWay_i][index] <= 1'b0;
      lru[index] <= ~fillWay_i;
    end else begin
      if (touch_i) begin
        lru[index] <= ~fillWay_i;
      end
      if (storeHit_i) begin
        dirty[fillWay_i][index] <= 1'b1;
      end
    end
  end

endmodule

//--- dcache/dataArray.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dataArray (
  input  logic                                     clk,
  input  logic [`DC_INDEX_W-1:0]                   index_i,
  input  logic [$clog2(`DC_LINE_WORDS)-1:0]        wordSel_i,
  input  dcache_pkg::wayOp_t                       op_i,
  input  logic                                     way_i,
  input  logic [`DC_WORD_W-1:0]                    storeData_i,
  input  logic [`DC_WORD_W/8-1:0]                  storeMask_i,
  input  logic [`DC_LINE_WORDS-1:0][`DC_WORD_W-1:0] fillLine_i,
  output logic [`DC_WORD_W-1:0]                    hitWord_o,
  output logic [`DC_LINE_WORDS-1:0][`DC_WORD_W-1:0] victimLine_o
);
  import dcache_pkg::*;

  logic [`DC_LINE_WORDS-1:0][`DC_WORD_W-1:0] lines [2][`DC_SETS];

  always_ff @(posedge clk) begin
    case (op_i)
      Store: begin
        // only the enabled byte lanes change
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
          if (storeMask_i[b]) begin
            lines[way_i][index_i][wordSel_i][b*8 +: 8] <= storeData_i[b*8 +: 8];
          end
        end
      end
      Fill: begin
        lines[way_i][index_i] <= fillLine_i;
      end
      default: begin
      end
    endcase
  end

  // a store answers with zero data
  assign hitWord_o = (op_i == Store) ? '0 : lines[way_i][index_i][wordSel_i];

  // whole line of the selected way, for write-back
  assign victimLine_o = lines[way_i][index_i];

endmodule

//--- dcache/lineBuffer.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module lineBuffer (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     beatValid_i,
  input  logic [`DC_WORD_W-1:0]                    beatData_i,
  input  logic                                     first_i,
  input  logic [`DC_LINE_WORDS-1:0][`DC_WORD_W-1:0] victimLine_i,
  input  logic [$clog2(`DC_LINE_WORDS)-1:0]        wbIndex_i,
  output logic [`DC_LINE_WORDS-1:0][`DC_WORD_W-1:0] fillLine_o,
  output logic [`DC_WORD_W-1:0]                    wbWord_o
);

  localparam int BeatW = $clog2(`DC_LINE_WORDS);

  logic [BeatW-1:0] beatCnt;

  // cleared while the refill request is pending
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (first_i) begin
      beatCnt <= '0;
    end else if (beatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // beats arrive in address order
  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      fillLine_o[beatCnt] <= beatData_i;
    end
  end

  // victim word for the current write beat
  assign wbWord_o = victimLine_i[wbIndex_i];

endmodule

//--- source/dcacheTop.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcacheTop (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    reqValid_i,
  input  dcache_pkg::cpuReq_t     req_i,
  output logic                    reqReady_o,
  output logic                    respValid_o,
  output dcache_pkg::cpuResp_t    resp_o,
  output logic                    memRdValid_o,
  output dcache_pkg::memRdReq_t   memRdReq_o,
  input  logic                    memRdReady_i,
  input  logic                    memRdDataValid_i,
  input  logic [`DC_WORD_W-1:0]   memRdData_i,
  input  logic                    memRdLast_i,
  output logic                    memWrValid_o,
  output dcache_pkg::memWrBeat_t  memWrBeat_o,
  output logic                    memWrLast_o,
  input  logic                    memWrReady_i
);
  import dcache_pkg::*;

  cpuReq_t latchedReq;
  wayOp_t dataOp;
  logic hit;
  logic hitWay;
  logic victimWay;
  logic victimDirty;
  logic opWay;
  logic tagFill;
  logic tagTouch;
  logic storeHit;
  logic fillBeat;
  logic [$clog2(`DC_LINE_WORDS)-1:0] wbIndex;
  logic [`DC_ADDR_W-1:0] victimAddr;
  logic [`DC_LINE_WORDS-1:0][`DC_WORD_W-1:0] fillLine;
  logic [`DC_LINE_WORDS-1:0][`DC_WORD_W-1:0] victimLine;
  logic [`DC_WORD_W-1:0] hitWord;
  logic [`DC_WORD_W-1:0] wbWord;

  assign resp_o.data = hitWord;
  assign memRdReq_o.addr = {latchedReq.addr[`DC_ADDR_W-1:`DC_OFFSET_W],
                            {`DC_OFFSET_W{1'b0}}};
  assign memWrBeat_o.addr = victimAddr;
  assign memWrBeat_o.data = wbWord;

  dcacheCtrl i_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .reqValid_i       (reqValid_i),
    .req_i            (req_i),
    .hit_i            (hit),
    .hitWay_i         (hitWay),
    .victimWay_i      (victimWay),
    .victimDirty_i    (victimDirty),
    .memRdReady_i     (memRdReady_i),
    .memRdDataValid_i (memRdDataValid_i),
    .memRdLast_i      (memRdLast_i),
    .memWrReady_i     (memWrReady_i),
    .reqReady_o       (reqReady_o),
    .latchedReq_o     (latchedReq),
    .respValid_o      (respValid_o),
    .dataOp_o         (dataOp),
    .opWay_o          (opWay),
    .tagFill_o        (tagFill),
    .tagTouch_o       (tagTouch),
    .storeHit_o       (storeHit),
    .fillBeat_o       (fillBeat),
    .wbIndex_o        (wbIndex),
    .memRdValid_o     (memRdValid_o),
    .memWrValid_o     (memWrValid_o),
    .memWrLast_o      (memWrLast_o)
  );

  tagStore i_tags (
    .clk           (clk),
    .rst_n         (rst_n),
    .addr_i        (latchedReq.addr),
    .fill_i        (tagFill),
    .touch_i       (tagTouch),
    .fillWay_i     (opWay),
    .storeHit_i    (storeHit),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimAddr_o  (victimAddr)
  );

  dataArray i_data (
    .clk          (clk),
    .index_i      (latchedReq.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
    .wordSel_i    (latchedReq.addr[3 +: $clog2(`DC_LINE_WORDS)]),
    .op_i         (dataOp),
    .way_i        (opWay),
    .storeData_i  (latchedReq.wrData),
    .storeMask_i  (latchedReq.byteMask),
    .fillLine_i   (fillLine),
    .hitWord_o    (hitWord),
    .victimLine_o (victimLine)
  );

  // the pending read request clears the beat counter
  lineBuffer i_lineBuf (
    .clk          (clk),
    .rst_n        (rst_n),
    .beatValid_i  (fillBeat),
    .beatData_i   (memRdData_i),
    .first_i      (memRdValid_o),
    .victimLine_i (victimLine),
    .wbIndex_i    (wbIndex),
    .fillLine_o   (fillLine),
    .wbWord_o     (wbWord)
  );

endmodule

//--- tests/dcache_assert.sv
`timescale 1ns/1ps

module dcache_assert (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   reqValid_i,
  input logic                   reqReady_o,
  input logic                   respValid_o,
  input logic                   hit,
  input logic                   memRdValid_o,
  input logic                   memWrValid_o,
  input logic                   memWrReady_i,
  input logic                   memWrLast_o,
  input dcache_pkg::memWrBeat_t memWrBeat_o
);

  int failCount = 0;
  int openReqs;
  logic accept;

  assign accept = reqValid_i && reqReady_o;

  // accepted requests still waiting for their response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      openReqs <= 0;
    end else begin
      openReqs <= openReqs + (accept ? 1 : 0) - (respValid_o ? 1 : 0);
    end
  end

  respAfterAccept: assert property (@(posedge clk) disable iff (!rst_n)
    respValid_o |-> openReqs > 0)
    else begin
      failCount++;
      $error("response without an accepted request");
    end

  oneMemPort: assert property (@(posedge clk) disable iff (!rst_n)
    !(memRdValid_o && memWrValid_o))
    else begin
      failCount++;
      $error("read and write requests are valid together");
    end

  // a stalled write beat keeps address, data and last flag
  wrBeatHeld: assert property (@(posedge clk) disable iff (!rst_n)
    memWrValid_o && !memWrReady_i |=>
      memWrValid_o && $stable(memWrBeat_o) && $stable(memWrLast_o))
    else begin
      failCount++;
      $error("write beat changed while not accepted");
    end

  hitRespondsNext: assert property (@(posedge clk) disable iff (!rst_n)
    accept ##1 hit |-> respValid_o)
    else begin
      failCount++;
      $error("hit did not respond in the cycle after acceptance");
    end

endmodule

bind dcacheTop dcache_assert i_assert (.*);

//--- tests/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tb;
  import dcache_pkg::*;

  // requests issued over all tests
  localparam int NumReqs = 13;
  localparam int CycleLimit = 200 * NumReqs;

  // three tags in set 3
  localparam logic [`DC_ADDR_W-1:0] LineA = 32'h0000_1060;
  localparam logic [`DC_ADDR_W-1:0] LineB = 32'h0000_2060;
  localparam logic [`DC_ADDR_W-1:0] LineC = 32'h0000_3060;

  logic clk;
  logic rst_n;
  logic reqValid_i;
  cpuReq_t req_i;
  logic reqReady_o;
  logic respValid_o;
  cpuResp_t resp_o;
  logic memRdValid_o;
  memRdReq_t memRdReq_o;
  logic memRdReady_i;
  logic memRdDataValid_i;
  logic [`DC_WORD_W-1:0] memRdData_i;
  logic memRdLast_i;
  logic memWrValid_o;
  memWrBeat_t memWrBeat_o;
  logic memWrLast_o;
  logic memWrReady_i;

  logic [`DC_WORD_W-1:0] memWords [logic [`DC_ADDR_W-1:0]];
  logic [7:0] refBytes [logic [`DC_ADDR_W-1:0]];
  cpuReq_t sendQ[$];
  logic [`DC_WORD_W-1:0] expQ[$];
  logic [`DC_ADDR_W-1:0] wrAddrQ[$];
  logic [`DC_WORD_W-1:0] wrDataQ[$];
  logic [`DC_ADDR_W-1:0] lastRdAddr;
  int rdBursts;
  int stalls;
  int errors;
  int checks;
  int testsRun;
  int testsFailed;
  int testStartErr;
  int cycles;
  string testName;

  dcacheTop i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcgStep(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory contents before any write, unique per word address
  function automatic logic [`DC_WORD_W-1:0] initWord(input logic [`DC_ADDR_W-1:0] a);
    logic [`DC_ADDR_W-1:0] w;
    w = {a[`DC_ADDR_W-1:3], 3'b000};
    return {w ^ 32'hA5C3_0F5A, ~w};
  endfunction

  function automatic logic [`DC_WORD_W-1:0] memRead(input logic [`DC_ADDR_W-1:0] a);
    return memWords.exists(a) ? memWords[a] : initWord(a);
  endfunction

  function automatic logic [`DC_WORD_W-1:0] refWord(input logic [`DC_ADDR_W-1:0] a);
    logic [`DC_ADDR_W-1:0] base;
    logic [`DC_WORD_W-1:0] w;
    base = {a[`DC_ADDR_W-1:3], 3'b000};
    w = initWord(base);
    for (int b = 0; b < 8; b++) begin
      if (refBytes.exists(base + b)) begin
        w[b*8 +: 8] = refBytes[base + b];
      end
    end
    return w;
  endfunction

  function automatic void refStore(input logic [`DC_ADDR_W-1:0] a,
                                   input logic [`DC_WORD_W-1:0] data,
                                   input logic [7:0] mask);
    logic [`DC_ADDR_W-1:0] base;
    base = {a[`DC_ADDR_W-1:3], 3'b000};
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) begin
        refBytes[base + b] = data[b*8 +: 8];
      end
    end
  endfunction

  function automatic int totalErrors();
    return errors + i_dut.i_assert.failCount;
  endfunction

  task automatic compareWord(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("mismatch %s, %s: expected %h, actual %h", testName, what, exp, act);
    end
  endtask

  task automatic requireTrue(input logic cond, input string msg);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("error in %s: %s", testName, msg);
    end
  endtask

  task automatic queueLoad(input logic [`DC_ADDR_W-1:0] a);
    sendQ.push_back('{addr: a, isWrite: 1'b0, wrData: '0, byteMask: '0});
  endtask

  task automatic queueStore(input logic [`DC_ADDR_W-1:0] a, input logic [63:0] data,
                            input logic [7:0] mask);
    sendQ.push_back('{addr: a, isWrite: 1'b1, wrData: data, byteMask: mask});
  endtask

  // keeps valid high until every queued request is taken, then waits for responses
  task automatic runRequests();
    logic ready;
    @(negedge clk);
    while (sendQ.size() > 0) begin
      reqValid_i = 1'b1;
      req_i = sendQ[0];
      ready = reqReady_o;
      @(posedge clk);
      if (ready) begin
        if (sendQ[0].isWrite) begin
          refStore(sendQ[0].addr, sendQ[0].wrData, sendQ[0].byteMask);
          expQ.push_back('0);
        end else begin
          expQ.push_back(refWord(sendQ[0].addr));
        end
        void'(sendQ.pop_front());
      end else begin
        // request waited a cycle for reqReady_o
        stalls++;
      end
      @(negedge clk);
    end
    reqValid_i = 1'b0;
    while (expQ.size() > 0) begin
      @(negedge clk);
    end
  endtask

  task automatic startTest(input string name);
    testName = name;
    testStartErr = totalErrors();
  endtask

  task automatic endTest();
    testsRun++;
    if (totalErrors() > testStartErr) begin
      testsFailed++;
      $display("test %s: failed with %0d errors", testName, totalErrors() - testStartErr);
    end else begin
      $display("test %s: passed", testName);
    end
  endtask

  // responses come back in request order
  always @(negedge clk) begin
    if (rst_n && respValid_o) begin
      if (expQ.size() == 0) begin
        errors++;
        $display("error in %s: response with no request outstanding", testName);
      end else begin
        compareWord("response data", expQ.pop_front(), resp_o.data);
      end
    end
  end

  initial begin : readPort
    logic [31:0] seed;
    logic [`DC_ADDR_W-1:0] base;
    int beat;
    seed = 32'd85;
    memRdReady_i = 1'b0;
    memRdDataValid_i = 1'b0;
    memRdData_i = '0;
    memRdLast_i = 1'b0;
    forever begin
      @(negedge clk);
      memRdReady_i = 1'b0;
      memRdDataValid_i = 1'b0;
      memRdLast_i = 1'b0;
      if (memRdValid_o) begin
        seed = lcgStep(seed);
        // ready about three cycles in four
        memRdReady_i = seed[16] | seed[17];
        if (memRdReady_i) begin
          base = memRdReq_o.addr;
          lastRdAddr = base;
          rdBursts++;
          beat = 0;
          while (beat < 4) begin
            @(negedge clk);
            memRdReady_i = 1'b0;
            memRdLast_i = 1'b0;
            seed = lcgStep(seed);
            memRdDataValid_i = seed[18] | seed[19];
            if (memRdDataValid_i) begin
              memRdData_i = memRead(base + 32'(beat * 8));
              memRdLast_i = (beat == 3);
              beat++;
            end
          end
        end
      end
    end
  end

  initial begin : writePort
    logic [31:0] seed;
    int beatIdx;
    seed = lcgStep(32'd85);
    memWrReady_i = 1'b0;
    beatIdx = 0;
    forever begin
      @(negedge clk);
      seed = lcgStep(seed);
      memWrReady_i = seed[20] | seed[21];
      if (memWrValid_o && memWrReady_i) begin
        // taken at the next rising edge
        requireTrue(memWrLast_o == (beatIdx == 3), "write last flag on the wrong beat");
        wrAddrQ.push_back(memWrBeat_o.addr);
        wrDataQ.push_back(memWrBeat_o.data);
        memWords[memWrBeat_o.addr + 32'(beatIdx * 8)] = memWrBeat_o.data;
        beatIdx = (beatIdx + 1) % 4;
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", CycleLimit);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int bursts;
    int wrCount;
    int stallCount;
    rst_n = 1'b0;
    reqValid_i = 1'b0;
    req_i = '0;
    errors = 0;
    checks = 0;
    testsRun = 0;
    testsFailed = 0;
    rdBursts = 0;
    stalls = 0;
    lastRdAddr = '0;
    testName = "reset";
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    startTest("reset");
    @(negedge clk);
    requireTrue(reqReady_o, "reqReady_o is low after reset");
    requireTrue(!respValid_o && !memRdValid_o && !memWrValid_o,
                "a valid output is high after reset");
    endTest();

    startTest("load miss");
    bursts = rdBursts;
    queueLoad(LineA + 8);
    runRequests();
    compareWord("read bursts", bursts + 1, rdBursts);
    compareWord("refill address", LineA, lastRdAddr);
    endTest();

    startTest("load hits");
    bursts = rdBursts;
    wrCount = wrDataQ.size();
    stallCount = stalls;
    for (int i = 0; i < 4; i++) begin
      queueLoad(LineA + 32'(i * 8));
    end
    runRequests();
    // hits are taken on consecutive edges
    compareWord("stalled request cycles", 0, stalls - stallCount);
    compareWord("read bursts", bursts, rdBursts);
    compareWord("write beats", wrCount, wrDataQ.size());
    endTest();

    startTest("masked store");
    queueStore(LineA + 16, 64'hDEAD_BEEF_0123_4567, 8'b0011_1100);
    queueLoad(LineA + 16);
    runRequests();
    endTest();

    // A is dirty and becomes LRU once B is filled, so C evicts A
    startTest("lru and write-back");
    queueStore(LineA + 24, 64'h0F1E_2D3C_4B5A_6978, 8'hFF);
    queueLoad(LineB);
    runRequests();
    wrCount = wrDataQ.size();
    queueLoad(LineC + 8);
    runRequests();
    compareWord("refill address", LineC, lastRdAddr);
    compareWord("write beats", wrCount + 4, wrDataQ.size());
    if (wrDataQ.size() >= wrCount + 4) begin
      for (int i = 0; i < 4; i++) begin
        compareWord("write-back address", LineA, wrAddrQ[wrCount + i]);
        compareWord("write-back data", refWord(LineA + 32'(i * 8)), wrDataQ[wrCount + i]);
      end
    end
    bursts = rdBursts;
    queueLoad(LineB + 16);
    runRequests();
    compareWord("read bursts on B reload", bursts, rdBursts);
    endTest();

    startTest("refill after eviction");
    bursts = rdBursts;
    wrCount = wrDataQ.size();
    queueLoad(LineA + 16);
    queueLoad(LineA + 24);
    runRequests();
    compareWord("read bursts", bursts + 1, rdBursts);
    compareWord("refill address", LineA, lastRdAddr);
    compareWord("write beats", wrCount, wrDataQ.size());
    endTest();

    @(negedge clk);
    $display("tests: %0d run, %0d failed; checks: %0d; errors: %0d",
             testsRun, testsFailed, checks, totalErrors());
    if (totalErrors() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+common
common/dcache_pkg.sv
dcache/dcacheCtrl.sv
dcache/tagStore.sv
dcache/dataArray.sv
dcache/lineBuffer.sv
source/dcacheTop.sv
tests/dcache_assert.sv
tests/dcache_tb.sv
